// ==== arch_regfile.sv ====
`timescale 1ns/10ps

module arch_regfile (
	input logic clock,
	input logic arst_n,
	input ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] commit,
	input logic [ooo_pkg::AREG_W-1:0] rd_addr,
	output logic [ooo_pkg::XLEN-1:0] rd_data
);

	import ooo_pkg::*;

	localparam int NREGS = 1 << AREG_W;

	logic [XLEN-1:0] regs [NREGS];

	// slot 0 is written last so the youngest commit to a register wins.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < NREGS; k++) begin
				regs[k] <= '0;
			end
		end else begin
			for (int i = WAYS - 1; i >= 0; i--) begin
				if (commit[i].valid && commit[i].kind == INSN_ALU) begin
					regs[commit[i].dest_reg] <= commit[i].result;
				end
			end
		end
	end

	assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// ==== ooo_pkg.sv ====
package ooo_pkg;

	// three-wide dispatch, completion and retirement.
	localparam int WAYS = 3;

	localparam int XLEN = 32;

	localparam int AREG_W = 5;

	// widest buffer index that a completion report can carry.
	localparam int ROB_IDX_MAX_W = 6;

	typedef enum logic [1:0] {
		INSN_ALU = 2'd0,
		INSN_BRANCH = 2'd1,
		INSN_NOP = 2'd2
	} insn_kind_e;

	typedef struct packed {
		logic valid;
		insn_kind_e kind;
		logic [AREG_W-1:0] dest_reg;
		logic [XLEN-1:0] pc;
	} dispatch_t;

	// one slot of the circular buffer.
	typedef struct packed {
		logic valid;
		insn_kind_e kind;
		logic [AREG_W-1:0] dest_reg;
		logic [XLEN-1:0] pc;
		logic completed;
		logic mispredict;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] target_pc;
	} rob_entry_t;

	// the buffer index is the low bits of rob_idx.
	typedef struct packed {
		logic valid;
		logic [ROB_IDX_MAX_W-1:0] rob_idx;
		logic mispredict;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] target_pc;
	} complete_t;

	typedef struct packed {
		logic valid;
		insn_kind_e kind;
		logic [AREG_W-1:0] dest_reg;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] result;
	} retire_t;

endpackage

// ==== retire_stage.sv ====
`timescale 1ns/10ps

module retire_stage (
	input logic clock,
	input logic arst_n,
	input ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] retire_cand,
	input logic [ooo_pkg::WAYS-1:0] cand_mispredict,
	input logic [ooo_pkg::WAYS-1:0][ooo_pkg::XLEN-1:0] cand_target_pc,
	output ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] commit,
	output logic recover,
	output logic [ooo_pkg::XLEN-1:0] redirect_pc
);

	import ooo_pkg::*;

	logic flush_req;
	logic [XLEN-1:0] flush_pc;

	// walk the candidates oldest first and stop after a mispredicted branch.
	always_comb begin
		logic stop;
		stop = recover;
		flush_req = 1'b0;
		flush_pc = '0;
		commit = retire_cand;
		for (int i = WAYS - 1; i >= 0; i--) begin
			commit[i].valid = retire_cand[i].valid & ~stop;
			if (commit[i].valid && cand_mispredict[i] &&
					retire_cand[i].kind == INSN_BRANCH) begin
				flush_req = 1'b1;
				flush_pc = cand_target_pc[i];
				stop = 1'b1;
			end
		end
	end

	// the pulse lasts one cycle because commits are blocked while it is high.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			recover <= 1'b0;
		end else begin
			recover <= flush_req;
		end
	end

	always_ff @(posedge clock) begin
		if (flush_req) begin
			redirect_pc <= flush_pc;
		end
	end

endmodule

// ==== rob.sv ====
`timescale 1ns/10ps

module rob #(
	parameter int ROB_DEPTH = 32
) (
	input logic clock,
	input logic arst_n,
	input ooo_pkg::dispatch_t [ooo_pkg::WAYS-1:0] dispatch,
	input ooo_pkg::complete_t [ooo_pkg::WAYS-1:0] complete,
	input logic recover,
	output logic [ooo_pkg::WAYS-1:0][$clog2(ROB_DEPTH)-1:0] dispatch_index,
	output logic [ooo_pkg::WAYS-1:0] struct_stall,
	output ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] retire_cand,
	output logic [ooo_pkg::WAYS-1:0] cand_mispredict,
	output logic [ooo_pkg::WAYS-1:0][ooo_pkg::XLEN-1:0] cand_target_pc
);

	import ooo_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = IDX_W + 1;

	rob_entry_t entries [ROB_DEPTH];

	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] tail;
	logic empty;

	logic [CNT_W-1:0] occupancy;
	logic [CNT_W-1:0] occupancy_next;
	logic [CNT_W-1:0] free_cnt;
	logic [1:0] n_disp;
	logic [1:0] n_acc;
	logic [1:0] n_ret;
	logic [WAYS-1:0][IDX_W-1:0] cand_ptr;

	// slot 2 is the oldest, so it sits at head and tail themselves.
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			cand_ptr[i] = head + IDX_W'(WAYS - 1 - i);
			dispatch_index[i] = tail + IDX_W'(WAYS - 1 - i);
		end
	end

	// head equal to tail means either empty or full.
	always_comb begin
		if (empty) begin
			occupancy = '0;
		end else if (tail == head) begin
			occupancy = CNT_W'(ROB_DEPTH);
		end else begin
			occupancy = {1'b0, tail - head};
		end
	end

	// longest run of completed entries starting at the head.
	always_comb begin
		logic run;
		rob_entry_t e;
		run = 1'b1;
		n_ret = '0;
		for (int i = WAYS - 1; i >= 0; i--) begin
			e = entries[cand_ptr[i]];
			run = run & e.valid & e.completed;
			retire_cand[i].valid = run;
			retire_cand[i].kind = e.kind;
			retire_cand[i].dest_reg = e.dest_reg;
			retire_cand[i].pc = e.pc;
			retire_cand[i].result = e.result;
			cand_mispredict[i] = run & e.mispredict;
			cand_target_pc[i] = e.target_pc;
			if (run) begin
				n_ret = n_ret + 2'd1;
			end
		end
	end

	// entries leaving this cycle count as free for dispatch.
	assign free_cnt = CNT_W'(ROB_DEPTH) - occupancy + CNT_W'(n_ret);

	always_comb begin
		if (free_cnt == CNT_W'(0)) begin
			struct_stall = 3'b111;
		end else if (free_cnt == CNT_W'(1)) begin
			struct_stall = 3'b011;
		end else if (free_cnt == CNT_W'(2)) begin
			struct_stall = 3'b001;
		end else begin
			struct_stall = 3'b000;
		end
	end

	always_comb begin
		if (!dispatch[2].valid) begin
			n_disp = 2'd0;
		end else if (!dispatch[1].valid) begin
			n_disp = 2'd1;
		end else if (!dispatch[0].valid) begin
			n_disp = 2'd2;
		end else begin
			n_disp = 2'd3;
		end
	end

	// a group arriving during recovery belongs to the wrong path.
	always_comb begin
		if (recover) begin
			n_acc = 2'd0;
		end else if (free_cnt < CNT_W'(n_disp)) begin
			n_acc = free_cnt[1:0];
		end else begin
			n_acc = n_disp;
		end
	end

	assign occupancy_next = occupancy - CNT_W'(n_ret) + CNT_W'(n_acc);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
			empty <= 1'b1;
		end else if (recover) begin
			head <= '0;
			tail <= '0;
			empty <= 1'b1;
		end else begin
			head <= head + IDX_W'(n_ret);
			tail <= tail + IDX_W'(n_acc);
			empty <= (occupancy_next == '0);
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < ROB_DEPTH; k++) begin
				entries[k] <= '0;
			end
		end else if (recover) begin
			for (int k = 0; k < ROB_DEPTH; k++) begin
				entries[k].valid <= 1'b0;
				entries[k].completed <= 1'b0;
			end
		end else begin
			for (int i = 0; i < WAYS; i++) begin
				if (retire_cand[i].valid) begin
					entries[cand_ptr[i]].valid <= 1'b0;
					entries[cand_ptr[i]].completed <= 1'b0;
				end
			end
			// a new entry may land in a slot freed above, so it comes later.
			for (int i = 0; i < WAYS; i++) begin
				if (2'(WAYS - 1 - i) < n_acc) begin
					entries[dispatch_index[i]] <= '{
						valid: 1'b1,
						kind: dispatch[i].kind,
						dest_reg: dispatch[i].dest_reg,
						pc: dispatch[i].pc,
						completed: 1'b0,
						mispredict: 1'b0,
						result: '0,
						target_pc: '0
					};
				end
			end
			for (int i = 0; i < WAYS; i++) begin
				if (complete[i].valid) begin
					entries[complete[i].rob_idx[IDX_W-1:0]].completed <= 1'b1;
					entries[complete[i].rob_idx[IDX_W-1:0]].mispredict <= complete[i].mispredict;
					entries[complete[i].rob_idx[IDX_W-1:0]].result <= complete[i].result;
					entries[complete[i].rob_idx[IDX_W-1:0]].target_pc <= complete[i].target_pc;
				end
			end
		end
	end

endmodule

// ==== rob_subsys.f ====
ooo_pkg.sv
rob.sv
retire_stage.sv
arch_regfile.sv
rob_subsys.sv
rob_subsys_chk.sv
tb_rob_subsys.sv

// ==== rob_subsys.sv ====
`timescale 1ns/10ps

module rob_subsys #(
	parameter int ROB_DEPTH = 32
) (
	input logic clock,
	input logic arst_n,
	input ooo_pkg::dispatch_t [ooo_pkg::WAYS-1:0] dispatch,
	input ooo_pkg::complete_t [ooo_pkg::WAYS-1:0] complete,
	output logic [ooo_pkg::WAYS-1:0][$clog2(ROB_DEPTH)-1:0] dispatch_index,
	output logic [ooo_pkg::WAYS-1:0] struct_stall,
	output ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] commit,
	output logic recover,
	output logic [ooo_pkg::XLEN-1:0] redirect_pc,
	input logic [ooo_pkg::AREG_W-1:0] rd_addr,
	output logic [ooo_pkg::XLEN-1:0] rd_data
);

	import ooo_pkg::*;

	retire_t [WAYS-1:0] retire_cand;
	logic [WAYS-1:0] cand_mispredict;
	logic [WAYS-1:0][XLEN-1:0] cand_target_pc;

	rob #(
		.ROB_DEPTH(ROB_DEPTH)
	) u_rob (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch(dispatch),
		.complete(complete),
		.recover(recover),
		.dispatch_index(dispatch_index),
		.struct_stall(struct_stall),
		.retire_cand(retire_cand),
		.cand_mispredict(cand_mispredict),
		.cand_target_pc(cand_target_pc)
	);

	retire_stage u_retire_stage (
		.clock(clock),
		.arst_n(arst_n),
		.retire_cand(retire_cand),
		.cand_mispredict(cand_mispredict),
		.cand_target_pc(cand_target_pc),
		.commit(commit),
		.recover(recover),
		.redirect_pc(redirect_pc)
	);

	// the commit slots double as the register file write ports.
	arch_regfile u_arch_regfile (
		.clock(clock),
		.arst_n(arst_n),
		.commit(commit),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

// ==== rob_subsys_chk.sv ====
`timescale 1ns/10ps

module rob_subsys_chk (
	input logic clock,
	input logic arst_n,
	input ooo_pkg::dispatch_t [ooo_pkg::WAYS-1:0] dispatch,
	input logic [ooo_pkg::WAYS-1:0] struct_stall,
	input ooo_pkg::retire_t [ooo_pkg::WAYS-1:0] commit,
	input logic recover
);

	import ooo_pkg::*;

	logic [WAYS-1:0] commit_valid;
	logic [WAYS-1:0] dispatch_valid;

	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			commit_valid[i] = commit[i].valid;
			dispatch_valid[i] = dispatch[i].valid;
		end
	end

	recover_single: assert property (@(posedge clock) disable iff (!arst_n)
		recover |=> !recover)
		else $error("recover stayed high for two cycles");

	no_commit_in_recover: assert property (@(posedge clock) disable iff (!arst_n)
		recover |-> commit_valid == '0)
		else $error("commit valid while recover is high");

	// slot 2 is the oldest, so valid commits fill down from it.
	commit_contiguous: assert property (@(posedge clock) disable iff (!arst_n)
		commit_valid inside {3'b000, 3'b100, 3'b110, 3'b111})
		else $error("commit valids are not contiguous from slot 2");

	no_stalled_dispatch: assert property (@(posedge clock) disable iff (!arst_n)
		(dispatch_valid & struct_stall) == '0)
		else $error("dispatch into a slot whose stall bit is set");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rob_subsys testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rob_subsys

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f rob_subsys.f \
	> "$LOG" 2>&1 \
	&& "./obj_dir/V$TOP" >> "$LOG" 2>&1 \
	|| echo "TESTS FAILED" >> "$LOG"

cat "$LOG"

grep -q "TESTS FAILED" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" "$LOG" || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

// ==== tb_rob_subsys.sv ====
`timescale 1ns/10ps

module tb_rob_subsys;

	import ooo_pkg::*;

	localparam int DEPTH = 8;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CLK_PERIOD = 100;
	// cycle budgets of the five tests, summed for the watchdog.
	localparam int TOTAL_CYCLES = 40 + 40 + 120 + 40 + 60;

	typedef struct packed {
		insn_kind_e kind;
		logic [AREG_W-1:0] dest;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] result;
		logic mispredict;
		logic [XLEN-1:0] target;
		logic [IDX_W-1:0] idx;
	} insn_t;

	logic clock;
	logic arst_n;
	dispatch_t [WAYS-1:0] dispatch;
	complete_t [WAYS-1:0] complete;
	logic [WAYS-1:0][IDX_W-1:0] dispatch_index;
	logic [WAYS-1:0] struct_stall;
	retire_t [WAYS-1:0] commit;
	logic recover;
	logic [XLEN-1:0] redirect_pc;
	logic [AREG_W-1:0] rd_addr;
	logic [XLEN-1:0] rd_data;

	// prog holds the current program in order and pending holds the entries not yet completed.
	insn_t prog[$];
	insn_t exp_commit[$];
	int pending[$];
	int disp_pos;
	logic [IDX_W-1:0] next_idx;
	logic [XLEN-1:0] next_pc;
	logic [XLEN-1:0] exp_redirect;
	logic [XLEN-1:0] ref_regs [32];
	integer seed;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	rob_subsys #(
		.ROB_DEPTH(DEPTH)
	) u_dut (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch(dispatch),
		.complete(complete),
		.dispatch_index(dispatch_index),
		.struct_stall(struct_stall),
		.commit(commit),
		.recover(recover),
		.redirect_pc(redirect_pc),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	bind rob_subsys rob_subsys_chk u_chk (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch(dispatch),
		.struct_stall(struct_stall),
		.commit(commit),
		.recover(recover)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(TOTAL_CYCLES * 2 * CLK_PERIOD);
		$display("watchdog: the simulation timed out before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int rand_below(input int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	function automatic void add_insn(input insn_kind_e kind, input logic [AREG_W-1:0] dest,
			input logic mispredict);
		insn_t t;
		t.kind = kind;
		t.dest = dest;
		t.pc = next_pc;
		t.result = $random(seed);
		t.mispredict = mispredict;
		t.target = next_pc + 32'h100;
		t.idx = '0;
		next_pc = next_pc + 32'd4;
		prog.push_back(t);
	endfunction

	// commits run in program order up to and including the first mispredicted branch.
	function automatic void reference_commits();
		logic stop;
		stop = 1'b0;
		foreach (prog[i]) begin
			if (!stop) begin
				exp_commit.push_back(prog[i]);
				if (prog[i].kind == INSN_ALU && prog[i].dest != '0) begin
					ref_regs[prog[i].dest] = prog[i].result;
				end
				if (prog[i].kind == INSN_BRANCH && prog[i].mispredict) begin
					exp_redirect = prog[i].target;
					stop = 1'b1;
				end
			end
		end
	endfunction

	function automatic logic [WAYS-1:0] stall_for_free(input int free);
		case (free)
			0: return 3'b111;
			1: return 3'b011;
			2: return 3'b001;
			default: return 3'b000;
		endcase
	endfunction

	task automatic start_program();
		prog.delete();
		pending.delete();
		disp_pos = 0;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#5;
		dispatch = '0;
		complete = '0;
	endtask

	// one cycle with up to want_disp dispatches and want_comp random completions.
	task automatic drive_cycle(input int want_disp, input int want_comp);
		int allowed;
		int n;
		int ncomp;
		int pick;
		int p;
		int fresh[$];
		next_cycle();
		allowed = 0;
		while (allowed < WAYS && !struct_stall[WAYS-1-allowed]) begin
			allowed++;
		end
		n = want_disp;
		if (n > allowed) begin
			n = allowed;
		end
		if (n > prog.size() - disp_pos) begin
			n = prog.size() - disp_pos;
		end
		for (int k = 0; k < n; k++) begin
			prog[disp_pos+k].idx = next_idx + IDX_W'(k);
			dispatch[WAYS-1-k].valid = 1'b1;
			dispatch[WAYS-1-k].kind = prog[disp_pos+k].kind;
			dispatch[WAYS-1-k].dest_reg = prog[disp_pos+k].dest;
			dispatch[WAYS-1-k].pc = prog[disp_pos+k].pc;
			fresh.push_back(disp_pos + k);
		end
		ncomp = (want_comp > pending.size()) ? pending.size() : want_comp;
		for (int c = 0; c < ncomp; c++) begin
			pick = rand_below(pending.size());
			p = pending[pick];
			pending.delete(pick);
			complete[c].valid = 1'b1;
			complete[c].rob_idx = ROB_IDX_MAX_W'(prog[p].idx);
			complete[c].mispredict = prog[p].mispredict;
			complete[c].result = prog[p].result;
			complete[c].target_pc = prog[p].target;
		end
		#1;
		for (int k = 0; k < n; k++) begin
			check(XLEN'(dispatch_index[WAYS-1-k]), XLEN'(prog[disp_pos+k].idx),
				"dispatch_index");
		end
		disp_pos += n;
		next_idx = next_idx + IDX_W'(n);
		foreach (fresh[j]) begin
			pending.push_back(fresh[j]);
		end
	endtask

	// instructions not yet dispatched stay at the back of exp_commit.
	task automatic drain(input int limit, input string what);
		int n;
		n = 0;
		while ((pending.size() > 0 || exp_commit.size() > prog.size() - disp_pos) &&
				n < limit) begin
			drive_cycle(0, WAYS);
			n++;
		end
		if (pending.size() > 0 || exp_commit.size() > prog.size() - disp_pos) begin
			errors++;
			$display("%s: instructions were still waiting to commit after %0d cycles",
				what, limit);
		end
	endtask

	task automatic expect_stall(input logic [WAYS-1:0] exp);
		next_cycle();
		check(XLEN'(struct_stall), XLEN'(exp), "struct_stall");
	endtask

	task automatic check_regs();
		for (int r = 0; r < 32; r++) begin
			next_cycle();
			rd_addr = AREG_W'(r);
			#1;
			check(rd_data, (r == 0) ? '0 : ref_regs[r], $sformatf("register x%0d", r));
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
		end
		$display("test %0d %s: %s with %0d errors", tests_run, name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		test_errors = errors;
	endtask

	// every valid commit slot, oldest first, must match the next expected instruction.
	always @(negedge clock) begin
		insn_t e;
		if (arst_n) begin
			for (int i = WAYS - 1; i >= 0; i--) begin
				if (commit[i].valid && exp_commit.size() == 0) begin
					check(XLEN'(commit[i].valid), '0,
						$sformatf("unexpected commit slot %0d", i));
				end else if (commit[i].valid) begin
					e = exp_commit.pop_front();
					check(commit[i].pc, e.pc, "commit pc");
					check(XLEN'(commit[i].kind), XLEN'(e.kind), "commit kind");
					check(XLEN'(commit[i].dest_reg), XLEN'(e.dest), "commit dest_reg");
					check(commit[i].result, e.result, "commit result");
				end
			end
		end
	end

	initial begin
		int n;
		logic got;
		seed = 32'hb4d4;
		arst_n = 1'b0;
		dispatch = '0;
		complete = '0;
		rd_addr = '0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		next_idx = '0;
		next_pc = 32'h1000;
		exp_redirect = '0;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		repeat (2) @(posedge clock);
		#5;
		arst_n = 1'b1;

		next_cycle();
		check(XLEN'(struct_stall), '0, "struct_stall after reset");
		check(XLEN'(recover), '0, "recover after reset");
		check(XLEN'({commit[2].valid, commit[1].valid, commit[0].valid}), '0,
			"commit valids after reset");
		check_regs();
		end_test("reset state");

		start_program();
		for (int i = 0; i < 12; i++) begin
			add_insn((i % 4 == 3) ? INSN_NOP : INSN_ALU, AREG_W'(rand_below(8)), 1'b0);
		end
		reference_commits();
		drive_cycle(1, 0);
		drive_cycle(2, 0);
		drive_cycle(3, 0);
		drain(40, "index test");
		drive_cycle(3, 0);
		drive_cycle(2, 0);
		drive_cycle(1, 0);
		drain(40, "index test");
		check(XLEN'(disp_pos), XLEN'(12), "instructions dispatched");
		end_test("dispatch indices");

		start_program();
		for (int i = 0; i < 30; i++) begin
			n = rand_below(4);
			if (n == 3) begin
				add_insn(INSN_BRANCH, AREG_W'(rand_below(8)), 1'b0);
			end else if (n == 2) begin
				add_insn(INSN_NOP, AREG_W'(rand_below(8)), 1'b0);
			end else begin
				add_insn(INSN_ALU, AREG_W'(rand_below(8)), 1'b0);
			end
		end
		reference_commits();
		n = 0;
		while (disp_pos < prog.size() && n < 100) begin
			drive_cycle(1 + rand_below(3), rand_below(4));
			n++;
		end
		drain(40, "random completion test");
		check_regs();
		end_test("out-of-order completion");

		// without completions the buffer fills and the stall follows the free count.
		start_program();
		for (int i = 0; i < DEPTH; i++) begin
			add_insn(INSN_ALU, AREG_W'(1 + rand_below(7)), 1'b0);
		end
		reference_commits();
		drive_cycle(3, 0);
		expect_stall(stall_for_free(DEPTH - disp_pos));
		drive_cycle(3, 0);
		expect_stall(stall_for_free(DEPTH - disp_pos));
		drive_cycle(1, 0);
		expect_stall(stall_for_free(DEPTH - disp_pos));
		drive_cycle(1, 0);
		expect_stall(stall_for_free(DEPTH - disp_pos));
		drain(40, "fill test");
		expect_stall(3'b000);
		end_test("structural stall");

		start_program();
		add_insn(INSN_ALU, 5'd9, 1'b0);
		add_insn(INSN_BRANCH, 5'd0, 1'b1);
		add_insn(INSN_ALU, 5'd10, 1'b0);
		add_insn(INSN_ALU, 5'd11, 1'b0);
		add_insn(INSN_ALU, 5'd12, 1'b0);
		reference_commits();
		drive_cycle(3, 0);
		drive_cycle(2, 3);
		n = 0;
		got = 1'b0;
		while (!got && n < 10) begin
			next_cycle();
			got = recover;
			n++;
		end
		if (!got) begin
			errors++;
			$display("recovery test: recover never went high after the mispredicted branch");
		end else begin
			check(redirect_pc, exp_redirect, "redirect_pc");
			// this group is on the wrong path and must be dropped.
			if (!struct_stall[2]) begin
				dispatch[2].valid = 1'b1;
				dispatch[2].kind = INSN_ALU;
				dispatch[2].dest_reg = 5'd13;
				dispatch[2].pc = 32'hdead0000;
			end
			next_cycle();
			check(XLEN'(recover), '0, "recover one cycle later");
		end
		next_idx = '0;
		start_program();
		add_insn(INSN_ALU, 5'd14, 1'b0);
		reference_commits();
		drive_cycle(1, 0);
		drain(40, "recovery test");
		check_regs();
		end_test("mispredict recovery");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
